/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = la_tb
FILELIST = project.f
BUILD    = obj_dir
PASS     = NO ERRORS

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	@out="$$(./$(BUILD)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS)"

clean:
	rm -rf $(BUILD)

/* logic/la_capture.sv */
`timescale 1ns/1ps

module la_capture #(
   parameter int count_width = 16
) (
   input  logic                           observer_clk,
   input  logic                           reset,
   input  logic [la_pkg::la_channels-1:0] channels,
   input  la_pkg::la_config_t             cfg,
   input  logic                           capture_go,
   output logic                           capturing,
   output logic                           fifo_wr,
   output la_pkg::la_fifo_word_t          fifo_wr_data
);

   import la_pkg::*;

   logic [count_width-1:0] ds_ctr;
   logic                   ds_strobe;     // One sample slot
   logic [count_width-1:0] sample_count;
   logic                   ticktock;      // High on the second sample of a pair
   la_fifo_word_t          pairs_q;

   // Downsample counter, drops samples rather than filtering
   always_ff @(posedge observer_clk) begin
      if (reset || capture_go) begin
         ds_ctr    <= '0;
         ds_strobe <= 1'b0;
      end else if (ds_ctr == cfg.downsample) begin
         ds_ctr    <= '0;
         ds_strobe <= 1'b1;
      end else begin
         ds_ctr    <= ds_ctr + 1'b1;
         ds_strobe <= 1'b0;
      end
   end

   // Capture control and FIFO write strobe
   always_ff @(posedge observer_clk) begin
      if (reset) begin
         capturing    <= 1'b0;
         sample_count <= '0;
         ticktock     <= 1'b0;
         fifo_wr      <= 1'b0;
      end else if (capture_go) begin
         capturing    <= 1'b1;
         sample_count <= '0;
         ticktock     <= 1'b0;
         fifo_wr      <= 1'b0;
      end else if (capturing && ds_strobe) begin
         ticktock     <= ~ticktock;
         fifo_wr      <= ticktock;   // Word complete after the second sample
         sample_count <= sample_count + 1'b1;
         if (sample_count == cfg.capture_depth - 1'b1)
            capturing <= 1'b0;
      end else begin
         fifo_wr <= 1'b0;
      end
   end

   // Shift each channel into its own bit pair
   always_ff @(posedge observer_clk) begin
      if (capturing && ds_strobe) begin
         for (int n = 0; n < la_channels; n++) begin
            pairs_q[2*n+1] <= pairs_q[2*n];
            pairs_q[2*n]   <= channels[n];
         end
      end
   end

   assign fifo_wr_data = pairs_q;

endmodule

/* logic/la_channel_select.sv */
`timescale 1ns/1ps

module la_channel_select (
   input  logic                           observer_clk,
   input  la_pkg::la_probes_t             probes,
   input  la_pkg::la_config_t             cfg,
   output logic [la_pkg::la_channels-1:0] channels
);

   import la_pkg::*;

   logic [la_channels-1:0] group_mux;

   // Group mux ahead of the capture register
   always_comb begin
      case (cfg.capture_group)
         la_group_glitch: begin
            group_mux = probes.glitch_group & la_glitch_mask;
         end
         la_group_io: begin
            group_mux = probes.io_group;
         end
         la_group_userio: begin
            group_mux = probes.userio_group;
         end
         la_group_debug: begin
            group_mux = probes.debug_group;
         end
         la_group_trace: begin
            group_mux = probes.trace_group;
         end
         default: begin
            group_mux = la_fixed_pattern;   // Known pattern for link checks
         end
      endcase
   end

   // One cycle of latency
   always_ff @(posedge observer_clk) begin
      channels <= group_mux;
   end

endmodule

/* logic/la_pkg.sv */
package la_pkg;

   localparam int la_channels   = 9;
   localparam int la_count_bits = 16;   // Depth and downsample fields

   typedef logic [7:0] la_addr_t;
   typedef logic [7:0] la_data_t;
   typedef logic [2:0] la_group_t;
   typedef logic [2:0] la_trig_src_t;

   // Two samples per channel, earlier sample in the upper bit of each pair
   typedef logic [2*la_channels-1:0] la_fifo_word_t;

   // Register map
   localparam la_addr_t la_capture_group_addr  = 8'd0;
   localparam la_addr_t la_status_addr         = 8'd1;   // Read only
   localparam la_addr_t la_trigger_source_addr = 8'd2;
   localparam la_addr_t la_capture_depth_addr  = 8'd3;   // Two bytes
   localparam la_addr_t la_downsample_addr     = 8'd4;   // Two bytes
   localparam la_addr_t la_arm_addr            = 8'd5;
   localparam la_addr_t la_manual_capture_addr = 8'd6;   // Write only

   // Capture groups, anything above trace gives the fixed pattern
   localparam la_group_t la_group_glitch = 3'd0;
   localparam la_group_t la_group_io     = 3'd1;
   localparam la_group_t la_group_userio = 3'd2;
   localparam la_group_t la_group_debug  = 3'd3;
   localparam la_group_t la_group_trace  = 3'd4;

   // Trigger sources, 5 to 7 never fire
   localparam la_trig_src_t la_trig_glitch_go      = 3'd0;
   localparam la_trig_src_t la_trig_capture_active = 3'd1;
   localparam la_trig_src_t la_trig_glitch_trigger = 3'd2;
   localparam la_trig_src_t la_trig_hs1            = 3'd3;
   localparam la_trig_src_t la_trig_debug0         = 3'd4;

   // Even channels high, odd channels low
   localparam logic [la_channels-1:0] la_fixed_pattern = 9'b1_0101_0101;

   // Glitch channels 1 and 8 have no source
   localparam logic [la_channels-1:0] la_glitch_mask = 9'b0_1111_1101;

   typedef struct packed {
      logic [la_channels-1:0] glitch_group;
      logic [la_channels-1:0] io_group;
      logic [la_channels-1:0] userio_group;
      logic [la_channels-1:0] debug_group;
      logic [la_channels-1:0] trace_group;
   } la_probes_t;

   typedef struct packed {
      la_trig_src_t             trigger_source;
      la_group_t                capture_group;
      logic                     manual_capture;
      logic [la_count_bits-1:0] capture_depth;   // Samples per capture
      logic [la_count_bits-1:0] downsample;      // Idle cycles between samples
   } la_config_t;

endpackage

/* logic/la_registers.sv */
`timescale 1ns/1ps

module la_registers #(
   parameter int count_width = 16
) (
   input  logic                 observer_clk,
   input  logic                 reset,
   input  la_pkg::la_addr_t     reg_address,
   input  logic                 reg_bytecnt,
   input  la_pkg::la_data_t     reg_datai,
   input  logic                 reg_read,
   input  logic                 reg_write,
   input  logic                 capture_go,
   input  logic                 capturing,
   input  logic                 fifo_empty,
   output la_pkg::la_data_t     reg_datao,
   output la_pkg::la_config_t   cfg,
   output logic                 arm_level,
   output logic                 fifo_flush
);

   import la_pkg::*;

   la_trig_src_t           trig_src_q;
   la_group_t              group_q;
   logic                   manual_q;
   logic [count_width-1:0] depth_q;
   logic [count_width-1:0] downsample_q;
   logic [3:0]             byte_lsb;   // Bit offset of the addressed byte

   assign byte_lsb = {reg_bytecnt, 3'b000};

   assign cfg = '{
      trigger_source: trig_src_q,
      capture_group:  group_q,
      manual_capture: manual_q,
      capture_depth:  depth_q,
      downsample:     downsample_q
   };

   // Configuration writes
   always_ff @(posedge observer_clk) begin
      if (reset) begin
         trig_src_q   <= '0;
         group_q      <= '0;
         manual_q     <= 1'b0;
         depth_q      <= '0;
         downsample_q <= '0;
      end else if (reg_write) begin
         case (reg_address)
            la_capture_group_addr:  group_q    <= reg_datai[2:0];
            la_trigger_source_addr: trig_src_q <= reg_datai[2:0];
            la_manual_capture_addr: manual_q   <= reg_datai[0];
            la_capture_depth_addr:  depth_q[byte_lsb +: 8]      <= reg_datai;
            la_downsample_addr:     downsample_q[byte_lsb +: 8] <= reg_datai;
            default: ;
         endcase
      end
   end

   // Arm stays set until the capture actually starts
   always_ff @(posedge observer_clk) begin
      if (reset) begin
         arm_level <= 1'b0;
      end else if (reg_write && (reg_address == la_arm_addr)) begin
         arm_level <= reg_datai[0];
      end else if (capture_go) begin
         arm_level <= 1'b0;
      end
   end

   // Flush request raised on arming, held until the FIFO drains
   always_ff @(posedge observer_clk) begin
      if (reset) begin
         fifo_flush <= 1'b0;
      end else if (fifo_empty) begin
         fifo_flush <= 1'b0;
      end else if (arm_level && !fifo_flush) begin
         fifo_flush <= 1'b1;
      end
   end

   // Combinational read-back
   always_comb begin
      reg_datao = '0;
      if (reg_read) begin
         case (reg_address)
            la_capture_group_addr:  reg_datao = {5'b0, group_q};
            la_status_addr:         reg_datao = {6'b0, capturing, 1'b0};
            la_trigger_source_addr: reg_datao = {5'b0, trig_src_q};
            la_capture_depth_addr:  reg_datao = depth_q[byte_lsb +: 8];
            la_downsample_addr:     reg_datao = downsample_q[byte_lsb +: 8];
            la_arm_addr:            reg_datao = {7'b0, arm_level};
            default:                reg_datao = '0;   // Manual capture is write only
         endcase
      end
   end

endmodule

/* logic/la_top.sv */
`timescale 1ns/1ps

module la_top #(
   parameter int count_width = 16
) (
   input  logic                  observer_clk,
   input  logic                  reset,
   input  la_pkg::la_addr_t      reg_address,
   input  logic                  reg_bytecnt,
   input  la_pkg::la_data_t      reg_datai,
   input  logic                  reg_read,
   input  logic                  reg_write,
   output la_pkg::la_data_t      reg_datao,
   input  la_pkg::la_probes_t    probes,
   input  logic                  fifo_empty,
   output logic                  fifo_wr,
   output la_pkg::la_fifo_word_t fifo_wr_data,
   output logic                  fifo_flush
);

   import la_pkg::*;

   la_config_t             cfg;
   logic                   arm_level;
   logic                   capture_go;   // Single-cycle start pulse
   logic                   capturing;
   logic [la_channels-1:0] channels;

   la_registers #(
      .count_width (count_width)
   ) u_registers (
      .observer_clk (observer_clk),
      .reset        (reset),
      .reg_address  (reg_address),
      .reg_bytecnt  (reg_bytecnt),
      .reg_datai    (reg_datai),
      .reg_read     (reg_read),
      .reg_write    (reg_write),
      .capture_go   (capture_go),
      .capturing    (capturing),
      .fifo_empty   (fifo_empty),
      .reg_datao    (reg_datao),
      .cfg          (cfg),
      .arm_level    (arm_level),
      .fifo_flush   (fifo_flush)
   );

   la_trigger u_trigger (
      .observer_clk (observer_clk),
      .reset        (reset),
      .probes       (probes),
      .cfg          (cfg),
      .arm_level    (arm_level),
      .capturing    (capturing),
      .capture_go   (capture_go)
   );

   la_channel_select u_channel_select (
      .observer_clk (observer_clk),
      .probes       (probes),
      .cfg          (cfg),
      .channels     (channels)
   );

   la_capture #(
      .count_width (count_width)
   ) u_capture (
      .observer_clk (observer_clk),
      .reset        (reset),
      .channels     (channels),
      .cfg          (cfg),
      .capture_go   (capture_go),
      .capturing    (capturing),
      .fifo_wr      (fifo_wr),
      .fifo_wr_data (fifo_wr_data)
   );

endmodule

/* logic/la_trigger.sv */
`timescale 1ns/1ps

module la_trigger (
   input  logic               observer_clk,
   input  logic               reset,
   input  la_pkg::la_probes_t probes,
   input  la_pkg::la_config_t cfg,
   input  logic               arm_level,
   input  logic               capturing,
   output logic               capture_go
);

   import la_pkg::*;

   logic       trig_src;
   logic       trig_async;
   logic [1:0] sync_q;      // Two-stage synchronizer
   logic       trig_r;
   logic       trig_r2;
   logic       arm_d;
   logic       armed;

   always_comb begin
      case (cfg.trigger_source)
         la_trig_glitch_go:      trig_src = probes.glitch_group[4];
         la_trig_capture_active: trig_src = probes.glitch_group[5];
         la_trig_glitch_trigger: trig_src = probes.glitch_group[7];
         la_trig_hs1:            trig_src = probes.io_group[4];
         la_trig_debug0:         trig_src = probes.debug_group[0];
         default:                trig_src = 1'b0;
      endcase
   end

   assign trig_async = trig_src | cfg.manual_capture;

   always_ff @(posedge observer_clk) begin
      if (reset) begin
         sync_q  <= '0;
         trig_r  <= 1'b0;
         trig_r2 <= 1'b0;
      end else begin
         {trig_r2, trig_r, sync_q} <= {trig_r, sync_q, trig_async};
      end
   end

   // Armed on a rising arm level, dropped once capture is under way
   always_ff @(posedge observer_clk) begin
      if (reset) begin
         arm_d <= 1'b0;
         armed <= 1'b0;
      end else begin
         arm_d <= arm_level;
         if (capturing)
            armed <= 1'b0;
         else if (arm_level && !arm_d)
            armed <= 1'b1;
      end
   end

   // Idle check keeps a held manual trigger from restarting a capture
   assign capture_go = trig_r & ~trig_r2 & armed & ~capturing;

endmodule

/* project.f */
logic/la_pkg.sv
logic/la_registers.sv
logic/la_trigger.sv
logic/la_channel_select.sv
logic/la_capture.sv
logic/la_top.sv
sim/la_tb.sv

/* sim/la_tb.sv */
`timescale 1ns/1ps

module la_tb;

   import la_pkg::*;

   localparam int poll_limit = 100;

   logic          observer_clk;
   logic          reset;
   la_addr_t      reg_address;
   logic          reg_bytecnt;
   la_data_t      reg_datai;
   logic          reg_read;
   logic          reg_write;
   la_data_t      reg_datao;
   la_probes_t    probes;
   logic          fifo_empty;
   logic          fifo_wr;
   la_fifo_word_t fifo_wr_data;
   logic          fifo_flush;

   int            mismatch_errors = 0;
   int            timeout_errors  = 0;
   logic [31:0]   lcg_state       = 32'd4;
   int            cycle_count     = 0;
   int            word_count      = 0;   // All fifo_wr pulses since reset
   int            word_base       = 0;   // Count at start of current capture
   int            wr_times[$];
   bit            check_words     = 0;
   la_fifo_word_t exp_word;
   la_data_t      rd;

   la_top #(.count_width(16)) DUT (
      .observer_clk (observer_clk),
      .reset        (reset),
      .reg_address  (reg_address),
      .reg_bytecnt  (reg_bytecnt),
      .reg_datai    (reg_datai),
      .reg_read     (reg_read),
      .reg_write    (reg_write),
      .reg_datao    (reg_datao),
      .probes       (probes),
      .fifo_empty   (fifo_empty),
      .fifo_wr      (fifo_wr),
      .fifo_wr_data (fifo_wr_data),
      .fifo_flush   (fifo_flush)
   );

   initial begin
      observer_clk = 1'b0;
      forever #10 observer_clk = ~observer_clk;
   end

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic la_probes_t random_probes();
      logic [63:0] r;
      r = {lcg_next(), lcg_next()};
      return r[44:0];
   endfunction

   // Constant probes give both samples of a pair the same bit
   function automatic la_fifo_word_t expected_word(input la_group_t group, input la_probes_t p);
      logic [la_channels-1:0] ch;
      la_fifo_word_t          w;
      case (group)
         3'd0: begin
            ch    = p.glitch_group;
            ch[1] = 1'b0;   // Unconnected glitch channels
            ch[8] = 1'b0;
         end
         3'd1: ch = p.io_group;
         3'd2: ch = p.userio_group;
         3'd3: ch = p.debug_group;
         3'd4: ch = p.trace_group;
         default: begin
            for (int n = 0; n < la_channels; n++)
               ch[n] = (n % 2 == 0);   // Even channels high
         end
      endcase
      for (int n = 0; n < la_channels; n++) begin
         w[2*n+1] = ch[n];
         w[2*n]   = ch[n];
      end
      return w;
   endfunction

   task automatic check_data(input string name, input la_data_t got, input la_data_t exp);
      if (got !== exp) begin
         mismatch_errors++;
         $display("mismatch at %0d ns: %s is %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_word(input string name, input la_fifo_word_t got,
                             input la_fifo_word_t exp);
      if (got !== exp) begin
         mismatch_errors++;
         $display("mismatch at %0d ns: %s is %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_count(input string name, input integer got, input integer exp);
      if (got !== exp) begin
         mismatch_errors++;
         $display("mismatch at %0d ns: %s is %0d, expected %0d", $time, name, got, exp);
      end
   endtask

   task automatic idle(input int cycles);
      repeat (cycles) @(negedge observer_clk);
   endtask

   task automatic write_reg(input la_addr_t addr, input logic bytecnt, input la_data_t data);
      @(negedge observer_clk);
      reg_address = addr;
      reg_bytecnt = bytecnt;
      reg_datai   = data;
      reg_write   = 1'b1;
      @(negedge observer_clk);
      reg_write   = 1'b0;
   endtask

   task automatic write_count(input la_addr_t addr, input logic [15:0] value);
      write_reg(addr, 1'b0, value[7:0]);   // Low byte first
      write_reg(addr, 1'b1, value[15:8]);
   endtask

   task automatic read_reg(input la_addr_t addr, input logic bytecnt, output la_data_t data);
      @(negedge observer_clk);
      reg_address = addr;
      reg_bytecnt = bytecnt;
      reg_read    = 1'b1;
      @(negedge observer_clk);
      data     = reg_datao;
      reg_read = 1'b0;
   endtask

   task automatic expect_reg(input la_addr_t addr, input logic bytecnt, input la_data_t exp,
                             input string name);
      read_reg(addr, bytecnt, rd);
      check_data(name, rd, exp);
   endtask

   // Polls status bit 1 and leaves the last read in rd
   task automatic wait_status(input logic busy, input string what);
      int polls;
      polls = 0;
      read_reg(la_status_addr, 1'b0, rd);
      while (rd[1] !== busy && polls < poll_limit) begin
         read_reg(la_status_addr, 1'b0, rd);
         polls++;
      end
      if (rd[1] !== busy) begin
         timeout_errors++;
         $display("timeout at %0d ns: %s", $time, what);
      end
   endtask

   task automatic wait_flush(input logic level, input string what);
      int cycles;
      cycles = 0;
      while (fifo_flush !== level && cycles < poll_limit) begin
         @(negedge observer_clk);
         cycles++;
      end
      if (fifo_flush !== level) begin
         timeout_errors++;
         $display("timeout at %0d ns: %s", $time, what);
      end
   endtask

   // Three-cycle pulse on io channel 4 or glitch channel 4
   task automatic pulse_trigger(input bit on_io);
      @(negedge observer_clk);
      if (on_io)
         probes.io_group[4] = 1'b1;
      else
         probes.glitch_group[4] = 1'b1;
      idle(3);
      probes.io_group[4]     = 1'b0;
      probes.glitch_group[4] = 1'b0;
   endtask

   task automatic manual_capture(input la_group_t group, input int depth, input int ds);
      la_probes_t p;
      write_reg(la_trigger_source_addr, 1'b0, 8'd5);   // No probe trigger
      write_reg(la_capture_group_addr, 1'b0, {5'b0, group});
      write_count(la_capture_depth_addr, depth[15:0]);
      write_count(la_downsample_addr, ds[15:0]);
      p = random_probes();
      probes = p;
      idle(4);
      exp_word    = expected_word(group, p);
      word_base   = word_count;
      check_words = 1'b1;
      write_reg(la_arm_addr, 1'b0, 8'd1);
      idle(2);
      write_reg(la_manual_capture_addr, 1'b0, 8'd1);
      wait_status(1'b1, "manual capture did not start");
      wait_status(1'b0, "manual capture did not finish");
      idle(4);
      check_count("fifo_wr words", word_count - word_base, depth / 2);
      write_reg(la_manual_capture_addr, 1'b0, 8'd0);
      idle(4);
      check_words = 1'b0;
   endtask

   // Counts writes and compares every word after the first of a capture
   always @(negedge observer_clk) begin
      cycle_count++;
      if (fifo_wr === 1'b1) begin
         wr_times.push_back(cycle_count);
         if (check_words && word_count > word_base)
            check_word("fifo_wr_data", fifo_wr_data, exp_word);
         word_count++;
      end
   end

   initial begin
      reset       = 1'b1;
      reg_address = '0;
      reg_bytecnt = 1'b0;
      reg_datai   = '0;
      reg_read    = 1'b0;
      reg_write   = 1'b0;
      probes      = '0;
      fifo_empty  = 1'b1;
      repeat (4) @(negedge observer_clk);
      reset = 1'b0;

      // Trigger ignored while never armed
      write_reg(la_trigger_source_addr, 1'b0, 8'd3);
      write_count(la_capture_depth_addr, 16'd8);
      word_base = word_count;
      pulse_trigger(1'b1);
      idle(12);
      check_count("words without arm", word_count - word_base, 0);

      write_reg(la_capture_group_addr, 1'b0, 8'd5);
      expect_reg(la_capture_group_addr, 1'b0, 8'd5, "capture_group");
      write_reg(la_trigger_source_addr, 1'b0, 8'd6);
      expect_reg(la_trigger_source_addr, 1'b0, 8'd6, "trigger_source");
      write_count(la_capture_depth_addr, 16'h1234);
      expect_reg(la_capture_depth_addr, 1'b0, 8'h34, "capture_depth low");
      expect_reg(la_capture_depth_addr, 1'b1, 8'h12, "capture_depth high");
      write_count(la_downsample_addr, 16'h5678);
      expect_reg(la_downsample_addr, 1'b0, 8'h78, "downsample low");
      expect_reg(la_downsample_addr, 1'b1, 8'h56, "downsample high");
      write_reg(la_arm_addr, 1'b0, 8'd1);
      expect_reg(la_arm_addr, 1'b0, 8'd1, "arm");
      write_reg(la_arm_addr, 1'b0, 8'd0);
      expect_reg(la_arm_addr, 1'b0, 8'd0, "arm");
      expect_reg(la_status_addr, 1'b0, 8'd0, "status");

      for (int g = 0; g <= 6; g++) begin
         if (g != 5)
            manual_capture(la_group_t'(g), 8, 0);
      end

      manual_capture(3'd1, 6, 3);
      for (int i = word_base + 1; i < word_count; i++)
         check_count("fifo_wr spacing", wr_times[i] - wr_times[i-1], 2 * (3 + 1));

      // Source 3 listens to io channel 4 only
      probes = '0;
      idle(4);
      write_reg(la_trigger_source_addr, 1'b0, 8'd3);
      write_reg(la_capture_group_addr, 1'b0, 8'd1);
      write_count(la_capture_depth_addr, 16'd8);
      write_count(la_downsample_addr, 16'd0);
      write_reg(la_arm_addr, 1'b0, 8'd1);
      idle(2);
      word_base = word_count;
      pulse_trigger(1'b0);
      idle(12);
      check_count("words from glitch channel 4", word_count - word_base, 0);
      pulse_trigger(1'b1);
      wait_status(1'b1, "capture did not start on io channel 4");
      check_data("status", rd, 8'h02);
      wait_status(1'b0, "capture on io channel 4 did not finish");
      idle(4);
      check_count("words from io channel 4", word_count - word_base, 4);

      expect_reg(la_arm_addr, 1'b0, 8'd0, "arm after capture");
      word_base = word_count;
      pulse_trigger(1'b1);
      idle(12);
      check_count("words without re-arm", word_count - word_base, 0);

      fifo_empty = 1'b0;
      write_reg(la_arm_addr, 1'b0, 8'd1);
      wait_flush(1'b1, "fifo_flush did not rise after arming");
      @(negedge observer_clk);
      fifo_empty = 1'b1;
      wait_flush(1'b0, "fifo_flush did not fall with fifo_empty high");
      write_reg(la_arm_addr, 1'b0, 8'd0);

      $display("%0d mismatches, %0d timeouts", mismatch_errors, timeout_errors);
      if (mismatch_errors == 0 && timeout_errors == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

endmodule
